//--- bench/lsu_top_tb.sv
// directed lsu tests on a byte reference model; timing support needed, run stops at 2000 cycles
`timescale 1ns/100ps
`include "lsu_consts.svh"

module lsu_top_tb;

  localparam int MAX_CYCLES = 2000;
  localparam int MEM_BYTES  = 4 * `LSU_MEM_WORDS;

  logic                 clkb;
  logic                 rstb;
  logic                 req_valid;
  logic                 req_ready;
  logic                 rsp_valid;
  logic                 rsp_ready;
  logic                 rsp_err;
  logic [`LSU_XLEN-1:0] req_instr;
  logic [`LSU_XLEN-1:0] req_rs1;
  logic [`LSU_XLEN-1:0] req_rs2;
  logic [`LSU_XLEN-1:0] rsp_data;
  logic [`LSU_XLEN-1:0] rsp_addr;
  logic [7:0]           ref_mem [MEM_BYTES];
  // expected responses in arrival order
  logic [`LSU_XLEN-1:0] exp_data [$];
  logic [`LSU_XLEN-1:0] exp_addr [$];
  logic                 exp_err [$];
  int                   cycles = 0;
  int                   errors = 0;
  int                   test_base = 0;
  int                   tests_run = 0;

  lsu_top lsu_top_inst (.*);

  always #4 clkb = ~clkb;

  always @(posedge clkb) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles", MAX_CYCLES);
      $display("Something failed");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (act !== exp) begin
      $display("FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  // sampled at the falling edge where the payload is stable
  always @(negedge clkb) begin
    if (rsp_valid === 1'b1 && rsp_ready) begin
      if (exp_data.size() == 0) begin
        $display("error at %0t: response with no request waiting for one", $time);
        errors++;
      end else begin
        check_value("rsp_data", exp_data.pop_front(), rsp_data);
        check_value("rsp_addr", exp_addr.pop_front(), rsp_addr);
        check_value("rsp_err", exp_err.pop_front(), rsp_err);
      end
    end
  end

  function automatic logic [31:0] rand_base();
    return ($urandom % MEM_BYTES) & 32'hffff_fffc;
  endfunction

  // builds the instruction, updates the model and sends one request
  task automatic mem_op(input lsu_pkg::mem_op_e op, input logic [31:0] rs1,
                        input logic [11:0] imm, input logic [31:0] data);
    logic [31:0] addr;
    logic [31:0] value;
    logic [2:0]  f3;
    bit          store;
    int          a;
    int          size;
    addr  = rs1 + {{20{imm[11]}}, imm};
    a     = addr % MEM_BYTES;
    store = op inside {lsu_pkg::OP_SB, lsu_pkg::OP_SH, lsu_pkg::OP_SW};
    case (op)
      lsu_pkg::OP_LH, lsu_pkg::OP_SH: f3 = 3'b001;
      lsu_pkg::OP_LW, lsu_pkg::OP_SW: f3 = 3'b010;
      lsu_pkg::OP_LBU:                f3 = 3'b100;
      lsu_pkg::OP_LHU:                f3 = 3'b101;
      default:                        f3 = 3'b000;
    endcase
    size = 1 << f3[1:0];
    if (op == lsu_pkg::OP_NONE) begin
      // addi
      req_instr = {imm, 5'd1, 3'b000, 5'd2, 7'b0010011};
    end else if (store) begin
      req_instr = {imm[11:5], 5'd3, 5'd1, f3, imm[4:0], 7'b0100011};
    end else begin
      req_instr = {imm, 5'd1, f3, 5'd2, 7'b0000011};
    end
    if (op != lsu_pkg::OP_NONE && addr % size != 0) begin
      exp_data.push_back(32'h0);
      exp_addr.push_back(addr);
      exp_err.push_back(1'b1);
    end else if (store) begin
      for (int i = 0; i < size; i++) begin
        ref_mem[a + i] = data[8*i +: 8];
      end
    end else if (op != lsu_pkg::OP_NONE) begin
      case (op)
        lsu_pkg::OP_LB:  value = {{24{ref_mem[a][7]}}, ref_mem[a]};
        lsu_pkg::OP_LH:  value = {{16{ref_mem[a+1][7]}}, ref_mem[a+1], ref_mem[a]};
        lsu_pkg::OP_LBU: value = {24'h0, ref_mem[a]};
        lsu_pkg::OP_LHU: value = {16'h0, ref_mem[a+1], ref_mem[a]};
        default:         value = {ref_mem[a+3], ref_mem[a+2], ref_mem[a+1], ref_mem[a]};
      endcase
      exp_data.push_back(value);
      exp_addr.push_back(addr);
      exp_err.push_back(1'b0);
    end
    req_rs1   = rs1;
    req_rs2   = data;
    req_valid = 1'b1;
    @(negedge clkb);
    while (!req_ready) begin
      @(negedge clkb);
    end
    @(posedge clkb);
    #1;
    req_valid = 1'b0;
  endtask

  task automatic end_test(input string name);
    while (exp_data.size() != 0) begin
      @(posedge clkb);
    end
    // a few more cycles to catch stray responses
    repeat (3) @(posedge clkb);
    #1;
    tests_run++;
    $display("test %0d %s done with %0d errors", tests_run, name, errors - test_base);
    test_base = errors;
  endtask

  task automatic word_store_load();
    logic [31:0] base;
    base = rand_base();
    mem_op(lsu_pkg::OP_SW, base, 12'h010, $urandom);
    mem_op(lsu_pkg::OP_LW, base, 12'h010, 32'h0);
    // response due two edges after the accepting edge
    @(posedge clkb);
    #1;
    check_value("rsp_valid", 32'd0, rsp_valid);
    @(posedge clkb);
    #1;
    check_value("rsp_valid", 32'd1, rsp_valid);
    end_test("word store and load");
  endtask

  task automatic byte_half_stores();
    logic [31:0] base;
    base = rand_base();
    for (int i = 0; i < 4; i++) begin
      mem_op(lsu_pkg::OP_SB, base, 12'(i), $urandom);
    end
    for (int i = 0; i < 2; i++) begin
      mem_op(lsu_pkg::OP_SH, base, 12'(4 + 2 * i), $urandom);
    end
    mem_op(lsu_pkg::OP_LW, base, 12'h000, 32'h0);
    mem_op(lsu_pkg::OP_LW, base, 12'h004, 32'h0);
    end_test("byte and halfword stores");
  endtask

  task automatic extension_rules();
    logic [31:0] base;
    base = rand_base();
    // top bit set in byte 3 and in the upper half
    mem_op(lsu_pkg::OP_SW, base, 12'h000, 32'h80f1_7f85);
    mem_op(lsu_pkg::OP_LB, base, 12'h003, 32'h0);
    mem_op(lsu_pkg::OP_LH, base, 12'h002, 32'h0);
    mem_op(lsu_pkg::OP_LBU, base, 12'h003, 32'h0);
    mem_op(lsu_pkg::OP_LHU, base, 12'h002, 32'h0);
    end_test("sign and zero extension");
  endtask

  task automatic misaligned_ops();
    logic [31:0] base;
    base = rand_base();
    mem_op(lsu_pkg::OP_SW, base, 12'h000, $urandom);
    mem_op(lsu_pkg::OP_LH, base, 12'h001, 32'h0);
    mem_op(lsu_pkg::OP_LW, base, 12'h002, 32'h0);
    mem_op(lsu_pkg::OP_SW, base, 12'h001, 32'hdead_beef);
    mem_op(lsu_pkg::OP_LW, base, 12'h000, 32'h0);
    end_test("misaligned accesses");
  endtask

  task automatic backpressure_order();
    logic [31:0] base [4];
    int          sent;
    for (int i = 0; i < 4; i++) begin
      base[i] = rand_base();
      mem_op(lsu_pkg::OP_SW, base[i], 12'h000, $urandom);
    end
    rsp_ready = 1'b0;
    sent      = 0;
    while (req_ready && sent < 16) begin
      mem_op(lsu_pkg::OP_LW, base[$urandom % 4], 12'h000, 32'h0);
      sent++;
    end
    if (req_ready) begin
      $display("error at %0t: req_ready stayed high under back-pressure", $time);
      errors++;
    end
    // oldest response held at the output while the queue stays full
    repeat (4) begin
      @(posedge clkb);
      #1;
      check_value("rsp_valid", 32'd1, rsp_valid);
      check_value("rsp_data", exp_data[0], rsp_data);
      check_value("req_ready", 32'd0, req_ready);
    end
    rsp_ready = 1'b1;
    end_test("back-pressure and ordering");
  endtask

  task automatic drop_and_wrap();
    logic [31:0] base;
    base = rand_base();
    mem_op(lsu_pkg::OP_SW, base, 12'h000, $urandom);
    mem_op(lsu_pkg::OP_LW, base, 12'h000, 32'h0);
    mem_op(lsu_pkg::OP_NONE, base, 12'h004, 32'h0);
    mem_op(lsu_pkg::OP_LW, base + 3 * MEM_BYTES, 12'h000, 32'h0);
    end_test("dropped instruction and address wrap");
  endtask

  initial begin
    clkb      = 1'b0;
    rstb      = 1'b1;
    req_valid = 1'b0;
    req_instr = '0;
    req_rs1   = '0;
    req_rs2   = '0;
    rsp_ready = 1'b1;
    ref_mem   = '{default: 8'h00};
    void'($urandom(35));
    repeat (5) @(posedge clkb);
    #1;
    rstb = 1'b0;
    check_value("req_ready", 32'd1, req_ready);
    check_value("rsp_valid", 32'd0, rsp_valid);
    word_store_load();
    byte_half_stores();
    extension_rules();
    misaligned_ops();
    backpressure_order();
    drop_and_wrap();
    $display("tests run %0d, errors %0d", tests_run, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- lsu_top.f
+incdir+verilog
verilog/lsu_pkg.sv
verilog/data_bram.sv
verilog/mem_op_decode.sv
verilog/mem_access.sv
verilog/load_result.sv
verilog/lsu_top.sv
bench/lsu_top_tb.sv

//--- run_sim.sh
#!/bin/bash
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module lsu_top_tb -f lsu_top.f \
  --Mdir obj_dir -o lsu_sim \
  && ./obj_dir/lsu_sim | tee sim.log \
  && grep -qx "Everything OK" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- verilog/data_bram.sv
// single port RAM with byte enables and one-cycle read; contents start at zero, no reset
`timescale 1ns/100ps
`include "lsu_consts.svh"

module data_bram (
  input  logic                             clkb,
  input  logic                             en,
  input  logic [3:0]                       we,
  input  logic [$clog2(`LSU_MEM_WORDS)-1:0] word_addr,
  input  logic [`LSU_XLEN-1:0]             wdata,
  output logic [`LSU_XLEN-1:0]             rdata
);

  localparam int LANES = `LSU_XLEN / 8;

  logic [`LSU_XLEN-1:0] mem [`LSU_MEM_WORDS];

  initial begin
    for (int i = 0; i < `LSU_MEM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  // write-first per lane
  // read data shows the bytes written on the same edge
  always_ff @(posedge clkb) begin
    if (en) begin
      for (int b = 0; b < LANES; b++) begin
        if (we[b]) begin
          mem[word_addr][8*b +: 8] <= wdata[8*b +: 8];
          rdata[8*b +: 8]          <= wdata[8*b +: 8];
        end else begin
          rdata[8*b +: 8]          <= mem[word_addr][8*b +: 8];
        end
      end
    end
  end

endmodule

//--- verilog/load_result.sv
// queue never overflows only if the sender honours space_avail as ready; depth is a power of two
`timescale 1ns/100ps
`include "lsu_consts.svh"

module load_result (
  input  logic                 clkb,
  input  logic                 rstb,
  input  logic                 acc_valid,
  input  lsu_pkg::mem_op_e     acc_op,
  input  logic [`LSU_XLEN-1:0] acc_addr,
  input  logic [`LSU_XLEN-1:0] acc_rdata,
  input  logic                 acc_err,
  output logic                 space_avail,
  output logic                 rsp_valid,
  input  logic                 rsp_ready,
  output logic [`LSU_XLEN-1:0] rsp_data,
  output logic [`LSU_XLEN-1:0] rsp_addr,
  output logic                 rsp_err
);

  localparam int          PW          = $clog2(`LSU_RSP_DEPTH);
  localparam logic [PW:0] SPACE_LIMIT = `LSU_RSP_DEPTH - 3;

  logic [`LSU_XLEN-1:0] data_q [`LSU_RSP_DEPTH];
  logic [`LSU_XLEN-1:0] addr_q [`LSU_RSP_DEPTH];
  logic                 err_q  [`LSU_RSP_DEPTH];
  logic [PW-1:0]        wr_ptr;
  logic [PW-1:0]        rd_ptr;
  logic [PW:0]          count;
  logic                 push;
  logic                 pop;
  logic [`LSU_XLEN-1:0] shifted;
  logic [7:0]           sel_byte;
  logic [15:0]          sel_half;
  logic [`LSU_XLEN-1:0] load_data;

  // byte and halfword pick from the read word
  assign shifted  = acc_rdata >> {acc_addr[1:0], 3'b000};
  assign sel_byte = shifted[7:0];
  assign sel_half = acc_addr[1] ? acc_rdata[31:16] : acc_rdata[15:0];

  always_comb begin
    if (acc_err) begin
      load_data = '0;
    end else begin
      case (acc_op)
        lsu_pkg::OP_LB:  load_data = {{(`LSU_XLEN-8){sel_byte[7]}}, sel_byte};
        lsu_pkg::OP_LH:  load_data = {{(`LSU_XLEN-16){sel_half[15]}}, sel_half};
        lsu_pkg::OP_LBU: load_data = {{(`LSU_XLEN-8){1'b0}}, sel_byte};
        lsu_pkg::OP_LHU: load_data = {{(`LSU_XLEN-16){1'b0}}, sel_half};
        default:         load_data = acc_rdata;
      endcase
    end
  end

  assign push = acc_valid;
  assign pop  = rsp_valid && rsp_ready;

  // response queue
  always_ff @(posedge clkb) begin
    if (push) begin
      data_q[wr_ptr] <= load_data;
      addr_q[wr_ptr] <= acc_addr;
      err_q[wr_ptr]  <= acc_err;
    end
  end

  always_ff @(posedge clkb) begin
    if (rstb) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign rsp_valid = (count != '0);
  assign rsp_data  = data_q[rd_ptr];
  assign rsp_addr  = addr_q[rd_ptr];
  assign rsp_err   = err_q[rd_ptr];

  // room kept for two items in flight plus the one being accepted
  assign space_avail = (count <= SPACE_LIMIT);

endmodule

//--- verilog/lsu_consts.svh
// lsu sizing; LSU_MEM_WORDS and LSU_RSP_DEPTH must be powers of two, queue depth at least 4
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// data and address width
`define LSU_XLEN 32

// data memory depth in 32-bit words
// the word index is the address above the byte offset, modulo this depth
`define LSU_MEM_WORDS 1024

// response queue entries
// three are held back for the two stages in flight and the request being accepted
`define LSU_RSP_DEPTH 4

`endif

//--- verilog/lsu_pkg.sv
// shared lsu types; holds only the memory operation code, no state enum is needed
package lsu_pkg;

  // decoded memory operation
  // OP_NONE marks instructions that are accepted and dropped
  typedef enum logic [3:0] {
    OP_NONE = 4'd0,
    // loads
    OP_LB   = 4'd1,
    OP_LH   = 4'd2,
    OP_LW   = 4'd3,
    OP_LBU  = 4'd4,
    OP_LHU  = 4'd5,
    // stores
    OP_SB   = 4'd6,
    OP_SH   = 4'd7,
    OP_SW   = 4'd8
  } mem_op_e;

endpackage

//--- verilog/lsu_top.sv
// load/store unit top; fixed two-cycle load latency, aligned stores give no response
`timescale 1ns/100ps
`include "lsu_consts.svh"

module lsu_top (
  input  logic                 clkb,
  input  logic                 rstb,
  // request side
  input  logic                 req_valid,
  output logic                 req_ready,
  input  logic [`LSU_XLEN-1:0] req_instr,
  input  logic [`LSU_XLEN-1:0] req_rs1,
  input  logic [`LSU_XLEN-1:0] req_rs2,
  // response side
  output logic                 rsp_valid,
  input  logic                 rsp_ready,
  output logic [`LSU_XLEN-1:0] rsp_data,
  output logic [`LSU_XLEN-1:0] rsp_addr,
  output logic                 rsp_err
);

  logic                 space_avail;
  // decode to execute
  logic                 dec_valid;
  lsu_pkg::mem_op_e     dec_op;
  logic [`LSU_XLEN-1:0] dec_addr;
  logic [`LSU_XLEN-1:0] dec_wdata;
  logic                 dec_misaligned;
  // execute to result
  logic                 acc_valid;
  lsu_pkg::mem_op_e     acc_op;
  logic [`LSU_XLEN-1:0] acc_addr;
  logic [`LSU_XLEN-1:0] acc_rdata;
  logic                 acc_err;

  mem_op_decode mem_op_decode_inst (
    .clkb           (clkb),
    .rstb           (rstb),
    .req_valid      (req_valid),
    .req_ready      (req_ready),
    .req_instr      (req_instr),
    .req_rs1        (req_rs1),
    .req_rs2        (req_rs2),
    .space_avail    (space_avail),
    .dec_valid      (dec_valid),
    .dec_op         (dec_op),
    .dec_addr       (dec_addr),
    .dec_wdata      (dec_wdata),
    .dec_misaligned (dec_misaligned)
  );

  mem_access mem_access_inst (
    .clkb           (clkb),
    .rstb           (rstb),
    .dec_valid      (dec_valid),
    .dec_op         (dec_op),
    .dec_addr       (dec_addr),
    .dec_wdata      (dec_wdata),
    .dec_misaligned (dec_misaligned),
    .acc_valid      (acc_valid),
    .acc_op         (acc_op),
    .acc_addr       (acc_addr),
    .acc_rdata      (acc_rdata),
    .acc_err        (acc_err)
  );

  load_result load_result_inst (
    .clkb        (clkb),
    .rstb        (rstb),
    .acc_valid   (acc_valid),
    .acc_op      (acc_op),
    .acc_addr    (acc_addr),
    .acc_rdata   (acc_rdata),
    .acc_err     (acc_err),
    .space_avail (space_avail),
    .rsp_valid   (rsp_valid),
    .rsp_ready   (rsp_ready),
    .rsp_data    (rsp_data),
    .rsp_addr    (rsp_addr),
    .rsp_err     (rsp_err)
  );

endmodule

//--- verilog/mem_access.sv
// one access per cycle with no stall; misaligned operations skip the RAM and return an error
`timescale 1ns/100ps
`include "lsu_consts.svh"

module mem_access (
  input  logic                 clkb,
  input  logic                 rstb,
  input  logic                 dec_valid,
  input  lsu_pkg::mem_op_e     dec_op,
  input  logic [`LSU_XLEN-1:0] dec_addr,
  input  logic [`LSU_XLEN-1:0] dec_wdata,
  input  logic                 dec_misaligned,
  output logic                 acc_valid,
  output lsu_pkg::mem_op_e     acc_op,
  output logic [`LSU_XLEN-1:0] acc_addr,
  output logic [`LSU_XLEN-1:0] acc_rdata,
  output logic                 acc_err
);

  localparam int AW = $clog2(`LSU_MEM_WORDS);

  logic [1:0]           byte_off;
  logic                 is_load;
  logic                 ram_en;
  logic [3:0]           ram_we;
  logic [`LSU_XLEN-1:0] ram_wdata;

  assign byte_off = dec_addr[1:0];
  assign is_load  = dec_op inside {lsu_pkg::OP_LB, lsu_pkg::OP_LH, lsu_pkg::OP_LW,
                                   lsu_pkg::OP_LBU, lsu_pkg::OP_LHU};
  assign ram_en   = dec_valid && !dec_misaligned;

  // move store data into the addressed byte lanes
  always_comb begin
    ram_we    = 4'b0000;
    ram_wdata = dec_wdata;
    case (dec_op)
      lsu_pkg::OP_SB: begin
        ram_we    = 4'b0001 << byte_off;
        ram_wdata = {{(`LSU_XLEN-8){1'b0}}, dec_wdata[7:0]} << {byte_off, 3'b000};
      end
      lsu_pkg::OP_SH: begin
        ram_we    = byte_off[1] ? 4'b1100 : 4'b0011;
        ram_wdata = {{(`LSU_XLEN-16){1'b0}}, dec_wdata[15:0]} << {byte_off, 3'b000};
      end
      lsu_pkg::OP_SW: ram_we = 4'b1111;
      default:        ram_we = 4'b0000;
    endcase
  end

  data_bram data_bram_inst (
    .clkb      (clkb),
    .en        (ram_en),
    .we        (ram_we),
    .word_addr (dec_addr[AW+1:2]),
    .wdata     (ram_wdata),
    .rdata     (acc_rdata)
  );

  // aligned stores need no response
  always_ff @(posedge clkb) begin
    if (rstb) begin
      acc_valid <= 1'b0;
    end else begin
      acc_valid <= dec_valid && (is_load || dec_misaligned);
    end
  end

  // tag travels beside the RAM read
  always_ff @(posedge clkb) begin
    acc_op   <= dec_op;
    acc_addr <= dec_addr;
    acc_err  <= dec_misaligned;
  end

endmodule

//--- verilog/mem_op_decode.sv
// accepts any instruction; only RV32I loads and stores raise dec_valid, the rest are dropped
`timescale 1ns/100ps
`include "lsu_consts.svh"

module mem_op_decode (
  input  logic                 clkb,
  input  logic                 rstb,
  input  logic                 req_valid,
  output logic                 req_ready,
  input  logic [`LSU_XLEN-1:0] req_instr,
  input  logic [`LSU_XLEN-1:0] req_rs1,
  input  logic [`LSU_XLEN-1:0] req_rs2,
  input  logic                 space_avail,
  output logic                 dec_valid,
  output lsu_pkg::mem_op_e     dec_op,
  output logic [`LSU_XLEN-1:0] dec_addr,
  output logic [`LSU_XLEN-1:0] dec_wdata,
  output logic                 dec_misaligned
);

  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

  logic [6:0]           opcode;
  logic [2:0]           funct3;
  logic [`LSU_XLEN-1:0] imm_i;
  logic [`LSU_XLEN-1:0] imm_s;
  logic [`LSU_XLEN-1:0] eff_addr;
  lsu_pkg::mem_op_e     op;
  logic                 misaligned;
  logic                 accept;

  // ready follows queue space only
  assign req_ready = space_avail;
  assign accept    = req_valid && req_ready;

  assign opcode = req_instr[6:0];
  assign funct3 = req_instr[14:12];

  // sign extended I-type and S-type immediates
  assign imm_i = {{(`LSU_XLEN-12){req_instr[31]}}, req_instr[31:20]};
  assign imm_s = {{(`LSU_XLEN-12){req_instr[31]}}, req_instr[31:25], req_instr[11:7]};

  assign eff_addr = req_rs1 + ((opcode == OPC_STORE) ? imm_s : imm_i);

  always_comb begin
    op = lsu_pkg::OP_NONE;
    if (opcode == OPC_LOAD) begin
      case (funct3)
        3'b000:  op = lsu_pkg::OP_LB;
        3'b001:  op = lsu_pkg::OP_LH;
        3'b010:  op = lsu_pkg::OP_LW;
        3'b100:  op = lsu_pkg::OP_LBU;
        3'b101:  op = lsu_pkg::OP_LHU;
        default: op = lsu_pkg::OP_NONE;
      endcase
    end else if (opcode == OPC_STORE) begin
      case (funct3)
        3'b000:  op = lsu_pkg::OP_SB;
        3'b001:  op = lsu_pkg::OP_SH;
        3'b010:  op = lsu_pkg::OP_SW;
        default: op = lsu_pkg::OP_NONE;
      endcase
    end
  end

  // halfwords need even addresses, words need a multiple of four
  always_comb begin
    case (op)
      lsu_pkg::OP_LH, lsu_pkg::OP_LHU, lsu_pkg::OP_SH: misaligned = eff_addr[0];
      lsu_pkg::OP_LW, lsu_pkg::OP_SW:                  misaligned = |eff_addr[1:0];
      default:                                         misaligned = 1'b0;
    endcase
  end

  always_ff @(posedge clkb) begin
    if (rstb) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= accept && (op != lsu_pkg::OP_NONE);
    end
  end

  always_ff @(posedge clkb) begin
    if (accept) begin
      dec_op         <= op;
      dec_addr       <= eff_addr;
      dec_wdata      <= req_rs2;
      dec_misaligned <= misaligned;
    end
  end

endmodule
